// File: include/crc24_config.svh
// CRC24 engine configuration

`ifndef CRC24_CONFIG_SVH
`define CRC24_CONFIG_SVH

////////////////////////////////////////
// CRC rule
////////////////////////////////////////

// generator polynomial without the implicit x^24 term, shifted in MSB first
`define CRC24_POLY 24'h328B63

// every burst starts from an all-ones remainder, no final inversion is applied
`define CRC24_INIT 24'hFFFFFF

////////////////////////////////////////
// beat geometry
////////////////////////////////////////

// payload word width in bits
`define CRC24_WORD_BITS 64

// at most this many words arrive in one beat, word 0 goes first on the wire
`define CRC24_MAX_WORDS 3

`endif

// File: hdl/crc24_pkg.sv
// CRC24 value types
`default_nettype none

`include "crc24_config.svh"

package crc24_pkg;

	// remainder of the CRC, also used for an evolved word contribution
	typedef logic [23:0] crc24_t;

	// one payload word as it comes off the link
	typedef logic [`CRC24_WORD_BITS-1:0] data_word_t;

	// one serial step of the MSB-first CRC
	// the evolve and zero-advance matrices are built from it at elaboration
	function automatic crc24_t crc24_shift_bit(crc24_t c, logic d);
		logic fb;
		crc24_t poly;
		fb = c[23] ^ d;
		poly = `CRC24_POLY;
		return {c[22:0], 1'b0} ^ ({$bits(crc24_t){fb}} & poly);
	endfunction

endpackage

`default_nettype wire

// File: hdl/stream_pkg.sv
// Beat framing types
`default_nettype none

`include "crc24_config.svh"

package stream_pkg;

	// number of valid words in a beat, legal values are 1 up to the maximum
	// a zero count never occurs on a legal beat
	typedef logic [$clog2(`CRC24_MAX_WORDS + 1)-1:0] word_count_t;

	// four-phase receiver states
	//   idle          waiting for req to rise
	//   acked         the cycle right after a beat was taken
	//   wait_release  ack held high until the source drops req
	typedef enum logic [1:0] {
		idle,
		acked,
		wait_release
	} ingress_state_t;

endpackage

`default_nettype wire

// File: hdl/beat_if.sv
// Framed beat interface
`default_nettype none
`timescale 1ns/1ps

`include "crc24_config.svh"

interface beat_if ();
	import crc24_pkg::*;
	import stream_pkg::*;

	// valid is a single-cycle strobe, the rest is only meaningful with it
	logic valid;
	logic sop;
	logic eop;
	word_count_t count;

	// word 0 is the oldest word of the beat on the wire
	data_word_t [`CRC24_MAX_WORDS-1:0] words;

	// the ingress drives a beat
	modport source (
		output valid, sop, eop, count, words
	);

	// evolvers and combiner consume it
	modport sink (
		input valid, sop, eop, count, words
	);

endinterface

`default_nettype wire

// File: hdl/crc24_beat_ingress.sv
// Four-phase beat receiver
`default_nettype none
`timescale 1ns/1ps

module crc24_beat_ingress (
	input  logic                    clk,
	input  logic                    arst,
	input  logic                    req,
	input  logic                    sop,
	input  logic                    eop,
	input  stream_pkg::word_count_t count,
	input  crc24_pkg::data_word_t   word_0,
	input  crc24_pkg::data_word_t   word_1,
	input  crc24_pkg::data_word_t   word_2,
	output logic                    ack,
	beat_if.source                  beat
);
	import stream_pkg::*;

	ingress_state_t state;
	logic take;

	// a beat is taken on the first edge that sees req high while idle
	// in every other state a new req just waits, which is all the
	// back-pressure the source ever sees
	assign take = (state == idle) && req;

	////////////////////////////////////////
	// handshake FSM
	////////////////////////////////////////

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			state <= idle;
			ack <= 1'b0;
			beat.valid <= 1'b0;
			beat.sop <= 1'b0;
			beat.eop <= 1'b0;
			beat.count <= '0;
		end else begin
			// valid only lives for the accept cycle
			beat.valid <= 1'b0;
			case (state)
				idle: begin
					if (req) begin
						state <= acked;
						ack <= 1'b1;
						beat.valid <= 1'b1;
						beat.sop <= sop;
						beat.eop <= eop;
						beat.count <= count;
					end
				end
				acked: begin
					// a fast source may already have released req
					if (!req) begin
						state <= idle;
						ack <= 1'b0;
					end else begin
						state <= wait_release;
					end
				end
				wait_release: begin
					if (!req) begin
						state <= idle;
						ack <= 1'b0;
					end
				end
				default: begin
					state <= idle;
					ack <= 1'b0;
				end
			endcase
		end
	end

	////////////////////////////////////////
	// payload capture
	////////////////////////////////////////

	// payload of the accepted beat, taken on the same edge as the framing
	always_ff @(posedge clk) begin
		if (take) begin
			beat.words <= {word_2, word_1, word_0};
		end
	end

endmodule

`default_nettype wire

// File: hdl/crc24_word_evolve.sv
// Zero-state CRC24 of one word
`default_nettype none
`timescale 1ns/1ps

`include "crc24_config.svh"

module crc24_word_evolve (
	input  logic                  clk,
	input  logic                  arst,
	input  logic                  ena,
	input  crc24_pkg::data_word_t word,
	output crc24_pkg::crc24_t     evo
);
	import crc24_pkg::*;

	// one column per data bit, column j is the CRC of a word holding only bit j
	typedef crc24_t [`CRC24_WORD_BITS-1:0] evo_matrix_t;

	// the whole word is shifted MSB first through a zeroed CRC for every column
	function automatic evo_matrix_t build_matrix();
		evo_matrix_t m;
		crc24_t c;
		for (int j = 0; j < `CRC24_WORD_BITS; j++) begin
			c = '0;
			for (int b = `CRC24_WORD_BITS - 1; b >= 0; b--) begin
				c = crc24_shift_bit(c, b == j);
			end
			m[j] = c;
		end
		return m;
	endfunction

	localparam evo_matrix_t EVO_MATRIX = build_matrix();

	crc24_t evo_next;

	// the CRC is linear, so the evolved word is the XOR of the columns
	// picked by its set bits
	always_comb begin
		evo_next = '0;
		for (int j = 0; j < `CRC24_WORD_BITS; j++) begin
			if (word[j]) begin
				evo_next = evo_next ^ EVO_MATRIX[j];
			end
		end
	end

	// one register stage, loaded with the beat strobe
	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			evo <= '0;
		end else if (ena) begin
			evo <= evo_next;
		end
	end

endmodule

`default_nettype wire

// File: hdl/crc24_zero_advance.sv
// CRC24 advance across zero words
`default_nettype none
`timescale 1ns/1ps

`include "crc24_config.svh"

module crc24_zero_advance #(
	parameter int SHIFT_WORDS = 1
) (
	input  crc24_pkg::crc24_t c,
	output crc24_pkg::crc24_t crc_out
);
	import crc24_pkg::*;

	localparam int SHIFT_BITS = SHIFT_WORDS * `CRC24_WORD_BITS;

	// column i is where remainder bit i ends up after the zero span
	typedef crc24_t [$bits(crc24_t)-1:0] adv_matrix_t;

	function automatic adv_matrix_t build_matrix();
		adv_matrix_t m;
		crc24_t r;
		for (int i = 0; i < $bits(crc24_t); i++) begin
			r = crc24_t'(1) << i;
			for (int n = 0; n < SHIFT_BITS; n++) begin
				r = crc24_shift_bit(r, 1'b0);
			end
			m[i] = r;
		end
		return m;
	endfunction

	localparam adv_matrix_t ADV_MATRIX = build_matrix();

	// pure XOR network, no state at all
	always_comb begin
		crc_out = '0;
		for (int i = 0; i < $bits(crc24_t); i++) begin
			if (c[i]) begin
				crc_out = crc_out ^ ADV_MATRIX[i];
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/crc24_beat_combine.sv
// CRC24 beat combiner
`default_nettype none
`timescale 1ns/1ps

`include "crc24_config.svh"

module crc24_beat_combine (
	input  logic              clk,
	input  logic              arst,
	beat_if.sink              beat,
	input  crc24_pkg::crc24_t evo_0,
	input  crc24_pkg::crc24_t evo_1,
	input  crc24_pkg::crc24_t evo_2,
	output crc24_pkg::crc24_t crc,
	output logic              crc_valid
);
	import crc24_pkg::*;
	import stream_pkg::*;

	logic valid_q;
	logic sop_q;
	logic eop_q;
	word_count_t count_q;
	crc24_t rem;
	crc24_t base;
	crc24_t base_x1, base_x2, base_x3;
	crc24_t word_sel;
	crc24_t word_x1, word_x2;
	crc24_t rem_next;

	////////////////////////////////////////
	// framing, one cycle late
	////////////////////////////////////////

	// the evolvers spend a cycle on the words, so framing follows them
	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			valid_q <= 1'b0;
			sop_q <= 1'b0;
			eop_q <= 1'b0;
			count_q <= '0;
		end else begin
			valid_q <= beat.valid;
			if (beat.valid) begin
				sop_q <= beat.sop;
				eop_q <= beat.eop;
				count_q <= beat.count;
			end
		end
	end

	////////////////////////////////////////
	// zero-span advances
	////////////////////////////////////////

	// a new burst restarts from all ones instead of the rolling value
	assign base = sop_q ? crc24_t'(`CRC24_INIT) : rem;

	crc24_zero_advance #(.SHIFT_WORDS(1)) base_adv_1_i (.c(base), .crc_out(base_x1));
	crc24_zero_advance #(.SHIFT_WORDS(2)) base_adv_2_i (.c(base), .crc_out(base_x2));
	crc24_zero_advance #(.SHIFT_WORDS(3)) base_adv_3_i (.c(base), .crc_out(base_x3));

	// with three words, word 1 needs one span and word 0 two
	// with two words only word 0 needs one span, so the single-span
	// advance is shared between them
	assign word_sel = (count_q == word_count_t'(3)) ? evo_1 : evo_0;

	crc24_zero_advance #(.SHIFT_WORDS(1)) word_adv_1_i (.c(word_sel), .crc_out(word_x1));
	crc24_zero_advance #(.SHIFT_WORDS(2)) word_adv_2_i (.c(evo_0), .crc_out(word_x2));

	// the newest word of the beat is never advanced
	always_comb begin
		case (count_q)
			word_count_t'(1): rem_next = base_x1 ^ evo_0;
			word_count_t'(2): rem_next = base_x2 ^ word_x1 ^ evo_1;
			word_count_t'(3): rem_next = base_x3 ^ word_x2 ^ word_x1 ^ evo_2;
			default:          rem_next = base;
		endcase
	end

	////////////////////////////////////////
	// rolling remainder and result
	////////////////////////////////////////

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			rem <= `CRC24_INIT;
			crc <= '0;
			crc_valid <= 1'b0;
		end else begin
			crc_valid <= valid_q && eop_q;
			if (valid_q) begin
				rem <= rem_next;
				// the consumer has to grab crc in the pulse cycle
				if (eop_q) begin
					crc <= rem_next;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/crc24_burst_engine.sv
// Burst CRC24 engine
`default_nettype none
`timescale 1ns/1ps

`include "crc24_config.svh"

module crc24_burst_engine (
	input  logic                    clk,
	input  logic                    arst,
	input  logic                    req,
	input  logic                    sop,
	input  logic                    eop,
	input  stream_pkg::word_count_t count,
	input  crc24_pkg::data_word_t   word_0,
	input  crc24_pkg::data_word_t   word_1,
	input  crc24_pkg::data_word_t   word_2,
	output logic                    ack,
	output crc24_pkg::crc24_t       crc,
	output logic                    crc_valid
);
	import crc24_pkg::*;

	// beat issued by the ingress, pulsing once per handshake
	beat_if beat_in ();

	// registered evolved words, one per word slot
	crc24_t [`CRC24_MAX_WORDS-1:0] evo;

	crc24_beat_ingress ingress_i (
		.clk    (clk),
		.arst   (arst),
		.req    (req),
		.sop    (sop),
		.eop    (eop),
		.count  (count),
		.word_0 (word_0),
		.word_1 (word_1),
		.word_2 (word_2),
		.ack    (ack),
		.beat   (beat_in.source)
	);

	// slots beyond count are evolved too and simply ignored downstream
	for (genvar i = 0; i < `CRC24_MAX_WORDS; i++) begin : g_evolve
		crc24_word_evolve evolve_i (
			.clk  (clk),
			.arst (arst),
			.ena  (beat_in.valid),
			.word (beat_in.words[i]),
			.evo  (evo[i])
		);
	end

	crc24_beat_combine combine_i (
		.clk       (clk),
		.arst      (arst),
		.beat      (beat_in.sink),
		.evo_0     (evo[0]),
		.evo_1     (evo[1]),
		.evo_2     (evo[2]),
		.crc       (crc),
		.crc_valid (crc_valid)
	);

endmodule

`default_nettype wire

// File: testbench/crc24_burst_engine_props.sv
// Burst engine handshake properties
`default_nettype none
`timescale 1ns/1ps

module crc24_burst_engine_props (
	input logic                    clk,
	input logic                    arst,
	input logic                    req,
	input logic                    eop,
	input stream_pkg::word_count_t count,
	input logic                    ack,
	input logic                    crc_valid
);

	// ack is low whenever the receiver is idle, so req high with ack low
	// on a rising edge is the edge at which a beat is taken
	logic accept;

	assign accept = req && !ack;

	////////////////////////////////////////
	// handshake
	////////////////////////////////////////

	// once ack is up it stays up for as long as req does
	ack_held: assert property (@(posedge clk) disable iff (arst)
		(ack && req) |=> ack)
		else $error("ack dropped while req was still high");

	// a zero word count is never offered on a live request
	count_legal: assert property (@(posedge clk) disable iff (arst)
		req |-> (count != '0))
		else $error("req raised with a zero word count");

	////////////////////////////////////////
	// result timing
	////////////////////////////////////////

	// ingress, evolver and combiner each add one register, so the pulse
	// is sampled three edges after the accept edge
	result_timing: assert property (@(posedge clk) disable iff (arst)
		crc_valid == $past(accept && eop, 3))
		else $error("crc_valid out of step with the accepted eop beat");

endmodule

bind crc24_burst_engine crc24_burst_engine_props props_i (
	.clk       (clk),
	.arst      (arst),
	.req       (req),
	.eop       (eop),
	.count     (count),
	.ack       (ack),
	.crc_valid (crc_valid)
);

`default_nettype wire

// File: testbench/tb_crc24_burst_engine.sv
// Burst CRC24 engine testbench
`default_nettype none
`timescale 1ns/1ps

`include "crc24_config.svh"

module tb_crc24_burst_engine;
	import crc24_pkg::*;
	import stream_pkg::*;

	////////////////////////////////////////
	// stimulus table
	////////////////////////////////////////

	// one row is a run of beats, sop follows from the eop of the beat before
	// counts hold one nibble per beat with beat 0 in the low nibble
	typedef struct packed {
		int unsigned n_beats;
		logic [31:0] counts;
		logic [7:0]  eop_mask;
		int unsigned n_results;
		int unsigned gap;
	} row_t;

	localparam int N_ROWS = 8;
	localparam row_t ROWS [N_ROWS] = '{
		// single-beat bursts with one, two and three words
		'{1, 32'h1, 8'h01, 1, 2},
		'{1, 32'h2, 8'h01, 1, 2},
		'{1, 32'h3, 8'h01, 1, 2},
		// longer bursts that walk through every zero-span advance
		'{4, 32'h3231, 8'h08, 1, 3},
		'{5, 32'h21312, 8'h10, 1, 1},
		// bursts back to back, each one restarts from the initial value
		'{4, 32'h3123, 8'h0A, 2, 0},
		'{3, 32'h133, 8'h07, 3, 0},
		'{6, 32'h211333, 8'h24, 2, 4}
	};

	logic clk;
	logic arst;
	logic req;
	logic sop;
	logic eop;
	word_count_t count;
	data_word_t word_0;
	data_word_t word_1;
	data_word_t word_2;
	logic ack;
	crc24_t crc;
	logic crc_valid;

	// bookkeeping shared by the driver and the monitor
	integer seed;
	int unsigned cyc;
	int unsigned cycle_limit;
	int unsigned value_errors;
	int unsigned other_errors;
	int unsigned results_seen;
	crc24_t ref_rem;
	logic ack_q;
	logic beat_eop_q [$];
	crc24_t exp_crc_q [$];
	int unsigned valid_due_q [$];

	crc24_burst_engine crc24_burst_engine_i (
		.clk       (clk),
		.arst      (arst),
		.req       (req),
		.sop       (sop),
		.eop       (eop),
		.count     (count),
		.word_0    (word_0),
		.word_1    (word_1),
		.word_2    (word_2),
		.ack       (ack),
		.crc       (crc),
		.crc_valid (crc_valid)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	////////////////////////////////////////
	// reference model and checks
	////////////////////////////////////////

	// bit-serial CRC, MSB of the word enters first
	function automatic crc24_t crc_serial_word(crc24_t c, data_word_t w);
		crc24_t r;
		logic fb;
		r = c;
		for (int b = `CRC24_WORD_BITS - 1; b >= 0; b--) begin
			fb = r[23] ^ w[b];
			r = r << 1;
			if (fb) begin
				r = r ^ crc24_t'(`CRC24_POLY);
			end
		end
		return r;
	endfunction

	// eight cycles per beat covers a handshake with the longest hold
	function automatic int unsigned run_cycle_limit();
		int unsigned beats;
		int unsigned gaps;
		beats = 0;
		gaps = 0;
		for (int r = 0; r < N_ROWS; r++) begin
			beats += ROWS[r].n_beats;
			gaps += ROWS[r].gap;
		end
		return beats * 8 + gaps + N_ROWS * 4 + 40;
	endfunction

	task automatic check_crc(crc24_t got, crc24_t exp, string what);
		if (got !== exp) begin
			value_errors++;
			$display("CHECK FAILED at %0t: %s, got %06h expected %06h", $time, what, got, exp);
		end
	endtask

	task automatic check_bit(logic got, logic exp, string what);
		if (got !== exp) begin
			value_errors++;
			$display("CHECK FAILED at %0t: %s, got %b expected %b", $time, what, got, exp);
		end
	endtask

	////////////////////////////////////////
	// driver
	////////////////////////////////////////

	// one four-phase handshake, the words are random and the reference
	// follows only the first n of them
	task automatic send_beat(logic first, logic last, word_count_t n);
		data_word_t w [3];
		int unsigned hold;
		int unsigned waited;
		for (int i = 0; i < 3; i++) begin
			w[i] = {$random(seed), $random(seed)};
		end
		if (first) begin
			ref_rem = `CRC24_INIT;
		end
		for (int i = 0; i < int'(n); i++) begin
			ref_rem = crc_serial_word(ref_rem, w[i]);
		end
		beat_eop_q.push_back(last);
		if (last) begin
			exp_crc_q.push_back(ref_rem);
		end
		sop = first;
		eop = last;
		count = n;
		word_0 = w[0];
		word_1 = w[1];
		word_2 = w[2];
		req = 1'b1;
		@(negedge clk);
		waited = 1;
		while (!ack && waited < 16) begin
			@(negedge clk);
			waited++;
		end
		if (!ack) begin
			other_errors++;
			$display("no ack came within 16 cycles of req at %0t", $time);
		end
		// keep req up a little longer, ack has to stay with it
		hold = {$random(seed)} % 3;
		repeat (hold) begin
			@(negedge clk);
			check_bit(ack, 1'b1, "ack while req is held high");
		end
		req = 1'b0;
		waited = 0;
		while (ack && waited < 16) begin
			@(negedge clk);
			waited++;
		end
		if (ack) begin
			other_errors++;
			$display("ack stayed high long after req was released, at %0t", $time);
		end
	endtask

	// waits for the monitor to count the results of one row
	task automatic wait_results(int unsigned base, int unsigned n_exp, int row);
		int unsigned waited;
		int unsigned seen;
		waited = 0;
		while (results_seen - base < n_exp && waited < 8) begin
			@(posedge clk);
			waited++;
		end
		seen = results_seen - base;
		@(negedge clk);
		if (seen != n_exp) begin
			other_errors++;
			$display("row %0d expected %0d results but %0d arrived", row, n_exp, seen);
		end
	endtask

	task automatic report_and_finish(bit timed_out);
		$display("errors: %0d value mismatches, %0d protocol or timing faults",
			value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0 && !timed_out) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	endtask

	////////////////////////////////////////
	// monitor
	////////////////////////////////////////

	// an accepted eop beat must give exactly one crc_valid two cycles
	// after ack rises, and no pulse is allowed anywhere else
	always @(negedge clk) begin : monitor
		logic due;
		logic last;
		if (!arst) begin
			if (ack && !ack_q) begin
				if (beat_eop_q.size() == 0) begin
					other_errors++;
					$display("ack rose at %0t with no beat offered", $time);
				end else begin
					last = beat_eop_q.pop_front();
					if (last) begin
						valid_due_q.push_back(cyc + 2);
					end
				end
			end
			due = (valid_due_q.size() > 0) && (valid_due_q[0] == cyc);
			check_bit(crc_valid, due, "crc_valid two cycles after an eop ack");
			if (due) begin
				void'(valid_due_q.pop_front());
			end
			if (crc_valid) begin
				results_seen++;
				if (exp_crc_q.size() == 0) begin
					other_errors++;
					$display("crc_valid at %0t while no result was pending", $time);
				end else begin
					check_crc(crc, exp_crc_q.pop_front(), "burst crc");
				end
			end
		end
		ack_q = ack;
	end

	initial begin
		cycle_limit = run_cycle_limit();
		while (cyc <= cycle_limit) begin
			@(posedge clk);
		end
		$display("timeout, the run went past its limit of %0d cycles", cycle_limit);
		report_and_finish(1'b1);
	end

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////

	initial begin
		seed = 17615;
		cyc = 0;
		value_errors = 0;
		other_errors = 0;
		results_seen = 0;
		ref_rem = `CRC24_INIT;
		ack_q = 1'b0;
		arst = 1'b1;
		req = 1'b0;
		sop = 1'b0;
		eop = 1'b0;
		count = '0;
		word_0 = '0;
		word_1 = '0;
		word_2 = '0;
		repeat (3) @(negedge clk);
		arst = 1'b0;
		@(negedge clk);
		// the engine comes out of reset quiet
		check_bit(ack, 1'b0, "ack after reset");
		check_bit(crc_valid, 1'b0, "crc_valid after reset");
		check_crc(crc, '0, "crc after reset");
		for (int r = 0; r < N_ROWS; r++) begin
			logic first;
			int unsigned base;
			base = results_seen;
			first = 1'b1;
			for (int b = 0; b < int'(ROWS[r].n_beats); b++) begin
				send_beat(first, ROWS[r].eop_mask[b], word_count_t'(ROWS[r].counts[4*b +: 4]));
				first = ROWS[r].eop_mask[b];
			end
			wait_results(base, ROWS[r].n_results, r);
			repeat (ROWS[r].gap) @(negedge clk);
		end
		report_and_finish(1'b0);
	end

endmodule

`default_nettype wire

// File: crc24_burst_engine.f
+incdir+include
hdl/crc24_pkg.sv
hdl/stream_pkg.sv
hdl/beat_if.sv
hdl/crc24_beat_ingress.sv
hdl/crc24_word_evolve.sv
hdl/crc24_zero_advance.sv
hdl/crc24_beat_combine.sv
hdl/crc24_burst_engine.sv
testbench/crc24_burst_engine_props.sv
testbench/tb_crc24_burst_engine.sv

// File: Makefile
# Verilator simulation of the burst CRC24 engine

VERILATOR ?= verilator
TOP       ?= tb_crc24_burst_engine
FILELIST  ?= crc24_burst_engine.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(FILELIST) $(wildcard include/*.svh hdl/*.sv testbench/*.sv)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BIN): $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

test: $(BIN)
	@./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Something failed" $(LOG) || \
		! grep -q "Everything OK" $(LOG); then \
		echo "test: simulation failed, see $(LOG)"; exit 1; \
	fi; \
	echo "test: simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
